/* files.f */
+incdir+hdl
hdl/i2s_pkg.sv
hdl/effect_pkg.sv
hdl/i2s_clock_gen.sv
hdl/i2s_rx_deser.sv
hdl/sample_effect.sv
hdl/i2s_tx_ser.sv
hdl/codec_audio_top.sv
verif/codec_audio_props.sv
verif/codec_audio_tb.sv

/* hdl/audio_params.svh */
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Sample word width, two's complement
`define SAMPLE_W 16

// System clocks per half period of BCLK
`define BCLK_HALF 8

// BCLK periods per LRCLK half period, one channel slot
`define BCLKS_PER_HALF 32

// One LRCLK half period is 2 * BCLK_HALF * BCLKS_PER_HALF system clocks
// (512 with the values above). MCLK runs at half the system clock

`endif

/* hdl/codec_audio_top.sv */
`include "audio_params.svh"

module codec_audio_top
  import i2s_pkg::*;
  import effect_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       adc_sdata,
  input  effect_op_e op,
  output logic       mclk,
  output logic       bclk,
  output logic       lrclk,
  output logic       dac_sdata,
  output logic       overrun
);

  logic                 bclk_rise;
  logic                 bclk_fall;
  logic                 lr_rise;
  logic                 lr_fall;

  logic                 rx_valid;
  logic [`SAMPLE_W-1:0] rx_sample;
  channel_e             rx_channel;
  logic                 eff_ready;

  logic                 eff_valid;
  logic [`SAMPLE_W-1:0] eff_sample;
  channel_e             eff_channel;
  logic                 tx_ready;

  i2s_clock_gen u_clk_gen (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mclk      (mclk),
    .bclk      (bclk),
    .lrclk     (lrclk),
    .bclk_rise (bclk_rise),
    .bclk_fall (bclk_fall),
    .lr_rise   (lr_rise),
    .lr_fall   (lr_fall)
  );

  // Decode
  i2s_rx_deser u_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .adc_sdata  (adc_sdata),
    .lrclk      (lrclk),
    .bclk_rise  (bclk_rise),
    .lr_rise    (lr_rise),
    .lr_fall    (lr_fall),
    .rx_ready   (eff_ready),
    .rx_valid   (rx_valid),
    .rx_sample  (rx_sample),
    .rx_channel (rx_channel),
    .overrun    (overrun)
  );

  // Execute
  sample_effect u_execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid    (rx_valid),
    .in_sample   (rx_sample),
    .in_channel  (rx_channel),
    .op          (op),
    .out_ready   (tx_ready),
    .in_ready    (eff_ready),
    .out_valid   (eff_valid),
    .out_sample  (eff_sample),
    .out_channel (eff_channel)
  );

  // Result
  i2s_tx_ser u_result (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid   (eff_valid),
    .in_sample  (eff_sample),
    .in_channel (eff_channel),
    .lr_rise    (lr_rise),
    .lr_fall    (lr_fall),
    .bclk_fall  (bclk_fall),
    .in_ready   (tx_ready),
    .dac_sdata  (dac_sdata)
  );

endmodule

/* hdl/effect_pkg.sv */
package effect_pkg;

  // Effect applied to each sample on its way to the DAC
  typedef enum logic [1:0] {
    OP_PASS   = 2'd0,  // Sample unchanged
    OP_MUTE   = 2'd1,  // Zero output
    OP_INVERT = 2'd2,  // Negate, most negative saturates to most positive
    OP_HALVE  = 2'd3   // Arithmetic shift right by one
  } effect_op_e;

endpackage

/* hdl/i2s_clock_gen.sv */
`include "audio_params.svh"

module i2s_clock_gen (
  input  logic clk_i,
  input  logic rst_ni,
  output logic mclk,
  output logic bclk,
  output logic lrclk,
  output logic bclk_rise,
  output logic bclk_fall,
  output logic lr_rise,
  output logic lr_fall
);

  localparam int unsigned BCNT_W = $clog2(`BCLK_HALF);
  localparam int unsigned LCNT_W = $clog2(`BCLKS_PER_HALF);

  logic [BCNT_W-1:0] bclk_cnt;
  logic [LCNT_W-1:0] lr_cnt;
  logic              bclk_term;
  logic              lr_term;

  assign bclk_term = (bclk_cnt == BCNT_W'(`BCLK_HALF - 1));

  // Strobes are high in the cycle whose clock edge toggles the output
  assign bclk_rise = bclk_term & ~bclk;
  assign bclk_fall = bclk_term & bclk;

  // LRCLK only moves together with a BCLK fall
  assign lr_term = bclk_fall & (lr_cnt == LCNT_W'(`BCLKS_PER_HALF - 1));
  assign lr_rise = lr_term & ~lrclk;
  assign lr_fall = lr_term & lrclk;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mclk <= 1'b0;
    end else begin
      mclk <= ~mclk;  // Half the system clock
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bclk_cnt <= '0;
      bclk     <= 1'b0;
    end else if (bclk_term) begin
      bclk_cnt <= '0;
      bclk     <= ~bclk;
    end else begin
      bclk_cnt <= bclk_cnt + 1'b1;
    end
  end

  // Counts complete BCLK periods within one channel slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lr_cnt <= '0;
      lrclk  <= 1'b0;
    end else if (lr_term) begin
      lr_cnt <= '0;
      lrclk  <= ~lrclk;
    end else if (bclk_fall) begin
      lr_cnt <= lr_cnt + 1'b1;
    end
  end

endmodule

/* hdl/i2s_pkg.sv */
package i2s_pkg;

  // Channel tag, same encoding as the LRCLK level
  typedef enum logic {
    CH_LEFT  = 1'b0,  // LRCLK low
    CH_RIGHT = 1'b1   // LRCLK high
  } channel_e;

  // Receiver half-frame sequence
  typedef enum logic [1:0] {
    RX_SKIP  = 2'd0,  // Waiting for the I2S delay bit
    RX_SHIFT = 2'd1,  // Shifting in the sample bits
    RX_DONE  = 2'd2   // Word handed over, idle until next LRCLK edge
  } rx_state_e;

endpackage

/* hdl/i2s_rx_deser.sv */
`include "audio_params.svh"

module i2s_rx_deser
  import i2s_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 adc_sdata,
  input  logic                 lrclk,
  input  logic                 bclk_rise,
  input  logic                 lr_rise,
  input  logic                 lr_fall,
  input  logic                 rx_ready,
  output logic                 rx_valid,
  output logic [`SAMPLE_W-1:0] rx_sample,
  output channel_e             rx_channel,
  output logic                 overrun
);

  localparam int unsigned CNT_W = $clog2(`BCLKS_PER_HALF);

  rx_state_e            state_q;
  logic [CNT_W-1:0]     bit_cnt;
  logic [`SAMPLE_W-1:0] shift_q;
  channel_e             ch_q;
  logic                 shift_en;
  logic                 word_done;

  assign shift_en  = (state_q == RX_SHIFT) && bclk_rise && (bit_cnt < CNT_W'(`SAMPLE_W));
  // First rise after the LSB hands the word over
  assign word_done = (state_q == RX_SHIFT) && bclk_rise && (bit_cnt == CNT_W'(`SAMPLE_W));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RX_DONE;  // Idle until the first LRCLK edge
      bit_cnt <= '0;
    end else if (lr_rise || lr_fall) begin
      state_q <= RX_SKIP;
      bit_cnt <= '0;
    end else begin
      case (state_q)
        RX_SKIP: if (bclk_rise) state_q <= RX_SHIFT;
        RX_SHIFT: begin
          if (shift_en) bit_cnt <= bit_cnt + 1'b1;
          if (word_done) state_q <= RX_DONE;
        end
        default: state_q <= RX_DONE;  // Rest of the slot is ignored
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    // LRCLK already carries the new level at the delay bit
    if ((state_q == RX_SKIP) && bclk_rise) ch_q <= channel_e'(lrclk);
    if (shift_en) shift_q <= {shift_q[`SAMPLE_W-2:0], adc_sdata};  // MSB first
  end

  // Output holding stage
  always_ff @(posedge clk_i) begin
    if (word_done) begin
      rx_sample  <= shift_q;
      rx_channel <= ch_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_valid <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      if (word_done) begin
        rx_valid <= 1'b1;
        if (rx_valid && !rx_ready) overrun <= 1'b1;  // Waiting word gets replaced
      end else if (rx_ready) begin
        rx_valid <= 1'b0;
      end
    end
  end

endmodule

/* hdl/i2s_tx_ser.sv */
`include "audio_params.svh"

module i2s_tx_ser
  import i2s_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 in_valid,
  input  logic [`SAMPLE_W-1:0] in_sample,
  input  channel_e             in_channel,
  input  logic                 lr_rise,
  input  logic                 lr_fall,
  input  logic                 bclk_fall,
  output logic                 in_ready,
  output logic                 dac_sdata
);

  logic                 hold_full;
  logic [`SAMPLE_W-1:0] hold_sample;
  channel_e             hold_channel;
  logic [`SAMPLE_W:0]   shift_q;  // Delay bit on top
  logic                 lr_edge;
  channel_e             next_channel;
  logic                 load;

  assign lr_edge      = lr_rise | lr_fall;
  assign next_channel = lr_rise ? CH_RIGHT : CH_LEFT;  // Level after the edge

  // Word only leaves at the start of its own channel slot
  assign load = lr_edge & hold_full & (hold_channel == next_channel);

  assign in_ready  = ~hold_full;
  assign dac_sdata = shift_q[`SAMPLE_W];

  always_ff @(posedge clk_i) begin
    if (in_valid && in_ready) begin
      hold_sample  <= in_sample;
      hold_channel <= in_channel;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_full <= 1'b0;
    end else if (load) begin
      hold_full <= 1'b0;
    end else if (in_valid && in_ready) begin
      hold_full <= 1'b1;
    end
  end

  // LRCLK edges share the cycle with a BCLK fall, the load wins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q <= '0;
    end else if (lr_edge) begin
      if (load) begin
        shift_q <= {1'b0, hold_sample};
      end else begin
        shift_q <= '0;  // Silent slot
      end
    end else if (bclk_fall) begin
      shift_q <= {shift_q[`SAMPLE_W-1:0], 1'b0};  // Zeros trail the LSB
    end
  end

endmodule

/* hdl/sample_effect.sv */
`include "audio_params.svh"

module sample_effect
  import i2s_pkg::*;
  import effect_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 in_valid,
  input  logic [`SAMPLE_W-1:0] in_sample,
  input  channel_e             in_channel,
  input  effect_op_e           op,
  input  logic                 out_ready,
  output logic                 in_ready,
  output logic                 out_valid,
  output logic [`SAMPLE_W-1:0] out_sample,
  output channel_e             out_channel
);

  localparam logic [`SAMPLE_W-1:0] S_MIN = {1'b1, {(`SAMPLE_W-1){1'b0}}};
  localparam logic [`SAMPLE_W-1:0] S_MAX = {1'b0, {(`SAMPLE_W-1){1'b1}}};

  logic [`SAMPLE_W-1:0] result;
  logic                 accept;

  // Output stage can take a new word while the old one leaves
  assign in_ready = ~out_valid | out_ready;
  assign accept   = in_valid & in_ready;

  always_comb begin
    case (op)
      OP_PASS:   result = in_sample;
      OP_MUTE:   result = '0;
      OP_INVERT: begin
        if (in_sample == S_MIN) begin
          result = S_MAX;  // -32768 has no positive twin
        end else begin
          result = -in_sample;
        end
      end
      OP_HALVE:  result = $signed(in_sample) >>> 1;  // Keeps the sign
      default:   result = in_sample;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_sample  <= result;
      out_channel <= in_channel;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator, run the testbench and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module codec_audio_tb \
  -f files.f \
  -o codec_audio_sim

# The simulation may stop with a non-zero status, the log decides
./obj_dir/codec_audio_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
  echo "Result: PASS"
else
  echo "Result: FAIL"
  exit 1
fi

/* verif/codec_audio_props.sv */
`include "audio_params.svh"

module codec_audio_props (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               in_valid,
  input logic               in_ready,
  input logic [`SAMPLE_W:0] in_data,   // Channel on top of the sample
  input logic               out_valid,
  input logic               out_ready,
  input logic [`SAMPLE_W:0] out_data,
  input logic               bclk,
  input logic               lrclk,
  input logic               bclk_rise,
  input logic               bclk_fall,
  input logic               lr_rise,
  input logic               lr_fall
);

  // A waiting word keeps valid and its data until the transfer
  in_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_valid && !in_ready |=> in_valid && $stable(in_data))
    else $error("input valid dropped or data changed before ready");

  out_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("output valid dropped or data changed before ready");

  // Each strobe marks the edge that moves the BCLK level, so the two never meet
  bclk_rise_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bclk_rise |=> $rose(bclk))
    else $error("bclk rise strobe without a rising bclk");

  bclk_fall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bclk_fall |=> $fell(bclk))
    else $error("bclk fall strobe without a falling bclk");

  // LRCLK edges sit on BCLK falls
  lr_on_fall_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lr_rise || lr_fall) |=> $changed(lrclk) && $fell(bclk))
    else $error("lrclk edge strobe not matched by lrclk and bclk edges");

endmodule

bind sample_effect codec_audio_props u_effect_props (
  .clk_i (clk_i), .rst_ni (rst_ni),
  .in_valid (in_valid), .in_ready (in_ready), .in_data ({in_channel, in_sample}),
  .out_valid (out_valid), .out_ready (out_ready), .out_data ({out_channel, out_sample}),
  .bclk (1'b0), .lrclk (1'b0),
  .bclk_rise (1'b0), .bclk_fall (1'b0), .lr_rise (1'b0), .lr_fall (1'b0)
);

bind i2s_clock_gen codec_audio_props u_clock_props (
  .clk_i (clk_i), .rst_ni (rst_ni),
  .in_valid (1'b0), .in_ready (1'b0), .in_data ('0),
  .out_valid (1'b0), .out_ready (1'b0), .out_data ('0),
  .bclk (bclk), .lrclk (lrclk),
  .bclk_rise (bclk_rise), .bclk_fall (bclk_fall), .lr_rise (lr_rise), .lr_fall (lr_fall)
);

/* verif/codec_audio_tb.sv */
`include "audio_params.svh"

module codec_audio_tb
  import i2s_pkg::*;
  import effect_pkg::*;
();

  localparam int N_ENTRIES   = 12;
  localparam int W           = `SAMPLE_W;
  localparam int HALF_CYC    = 2 * `BCLK_HALF * `BCLKS_PER_HALF;  // One LRCLK half period
  localparam int TIMEOUT_CYC = (N_ENTRIES + 3) * HALF_CYC;

  typedef struct packed {
    logic [W-1:0] sample;
    effect_op_e   op;
    logic [W-1:0] exp_word;
  } entry_t;

  logic       clk_i;
  logic       rst_ni;
  logic       adc_sdata;
  effect_op_e op;
  logic       mclk;
  logic       bclk;
  logic       lrclk;
  logic       dac_sdata;
  logic       overrun;

  entry_t     vectors [N_ENTRIES];
  int         err_cnt   = 0;
  int         cycle_cnt = 0;

  codec_audio_top DUT (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .adc_sdata (adc_sdata),
    .op        (op),
    .mclk      (mclk),
    .bclk      (bclk),
    .lrclk     (lrclk),
    .dac_sdata (dac_sdata),
    .overrun   (overrun)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: DAC words not complete after %0d clock cycles", cycle_cnt);
      $display("sim failed");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Sample, opcode, expected DAC word
  task automatic load_vectors();
    vectors[0]  = '{16'h1234, OP_PASS,   16'h1234};
    vectors[1]  = '{16'hbeef, OP_PASS,   16'hbeef};
    vectors[2]  = '{16'h7abc, OP_MUTE,   16'h0000};
    vectors[3]  = '{16'h8001, OP_MUTE,   16'h0000};
    vectors[4]  = '{16'h8000, OP_INVERT, 16'h7fff};  // Saturates
    vectors[5]  = '{16'h0001, OP_INVERT, 16'hffff};
    vectors[6]  = '{16'hff00, OP_INVERT, 16'h0100};
    vectors[7]  = '{16'h7fff, OP_INVERT, 16'h8001};
    vectors[8]  = '{16'h4000, OP_HALVE,  16'h2000};
    vectors[9]  = '{16'h8000, OP_HALVE,  16'hc000};
    vectors[10] = '{16'hffff, OP_HALVE,  16'hffff};  // -1 stays -1
    vectors[11] = '{16'hfffd, OP_HALVE,  16'hfffe};
  endtask

  // First received slot follows the first LRCLK rise, so entries start on the right
  function automatic logic entry_channel(input int idx);
    return (idx % 2 == 0) ? CH_RIGHT : CH_LEFT;
  endfunction

  // ADC bit after BCLK fall number idx of a slot, fall 0 being the LRCLK edge
  function automatic logic codec_bit(input int slot, input int idx);
    logic [W-1:0] word;
    if (slot < 1 || slot > N_ENTRIES || idx < 1 || idx > W) begin
      return 1'b0;  // Delay bit, padding and idle slots
    end
    word = vectors[slot-1].sample;
    return word[W-idx];
  endfunction

  initial begin
    int           slot;      // Half-frame number, 0 before the first LRCLK edge
    int           fall_idx;
    int           rise_idx;
    int           cyc_bclk;
    logic         bclk_prev;
    logic         lr_prev;
    logic         mclk_prev;
    logic [W-1:0] cap;
    logic [W-1:0] exp_word;
    bit           done;

    rst_ni    = 1'b0;
    adc_sdata = 1'b0;
    op        = OP_PASS;
    load_vectors();
    slot      = 0;
    fall_idx  = 0;
    rise_idx  = 0;
    cyc_bclk  = 0;
    bclk_prev = 1'b0;
    lr_prev   = 1'b0;
    mclk_prev = 1'b0;
    cap       = '0;
    done      = 1'b0;

    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    while (!done) begin
      @(negedge clk_i);  // DUT outputs settled since the last rising edge
      cyc_bclk++;
      check_val("mclk", mclk, !mclk_prev);
      check_val("overrun", overrun, 1'b0);

      if (lrclk != lr_prev) begin
        check_val("bclk rises per lrclk half", rise_idx, `BCLKS_PER_HALF);
        slot++;
        rise_idx = 0;
        fall_idx = 0;
        if (slot >= 1 && slot <= N_ENTRIES) begin
          op = vectors[slot-1].op;
          check_val("lrclk", lrclk, entry_channel(slot - 1));
        end else begin
          op = OP_PASS;
        end
      end

      if (bclk != bclk_prev) begin
        check_val("bclk half period", cyc_bclk, `BCLK_HALF);
        cyc_bclk = 0;
        if (!bclk) begin
          adc_sdata = codec_bit(slot, fall_idx);  // Codec drives after the fall
          fall_idx++;
        end else begin
          rise_idx++;
          if (rise_idx == 1) begin
            check_val("dac_sdata delay bit", dac_sdata, 1'b0);
          end else if (rise_idx <= W + 1) begin
            cap = {cap[W-2:0], dac_sdata};
          end
          if (rise_idx == W + 1) begin
            if (slot >= 3) begin
              exp_word = vectors[slot-3].exp_word;  // Two slots of latency
            end else begin
              exp_word = '0;  // Nothing processed yet
            end
            check_val("dac word", cap, exp_word);
            if (slot == N_ENTRIES + 2) begin
              done = 1'b1;
            end
          end
        end
      end

      bclk_prev = bclk;
      lr_prev   = lrclk;
      mclk_prev = mclk;
    end

    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
